// File: hdl/xcvr_cfg.svh
// build-time configuration of the loopback data path
// the product of XCVR_SER_WORDS and XCVR_SKIP_WORD must not exceed 4
`ifndef XCVR_CFG_SVH
`define XCVR_CFG_SVH

// number of transceiver lanes
`define XCVR_LANES       2
// data words per lane per cycle, one of 1, 2 or 4
`define XCVR_SER_WORDS   2
// bundle spacing multiplier inside the native lane word, 1 or 2
`define XCVR_SKIP_WORD   2

// fabric to PCS bundles carry 8 data bits plus 3 control bits
`define XCVR_TX_BUNDLE   11
// PCS to fabric bundles carry 8 data bits plus 8 status bits
`define XCVR_RX_BUNDLE   16
`define XCVR_TX_LANE_W   44
`define XCVR_RX_LANE_W   64

// word aligner thresholds
`define XCVR_SYNC_COMMAS 3
`define XCVR_SYNC_LOSS   4

`endif

// File: hdl/xcvr_pkg.sv
// word types shared by the adapter, the monitor and the top level
// the 8-bit base factor is the only one supported
`default_nettype none

package xcvr_pkg;

    // ************************************************************
    // TX word
    // ************************************************************

    // field order follows the native TX bundle so that a word can be
    // dropped into its 11-bit slot as is
    // bit 10 is the disparity value, 9 forces disparity, 8 marks a K code
    typedef struct packed {
        logic       dispval;
        logic       forcedisp;
        logic       k;
        logic [7:0] data;
    } tx_word_t;

    // ************************************************************
    // RX word status
    // ************************************************************

    // decoded status of one received word
    // the rate-match FIFO bits of the native bundle are not carried
    typedef struct packed {
        // running disparity after this word, 0 is negative
        logic       runningdisp;
        // set on a K28.5 comma
        logic       patterndetect;
        logic       disperr;
        // word aligner state of the lane
        logic       syncstatus;
        // code violation
        logic       errdetect;
        logic       k;
        logic [7:0] data;
    } rx_word_t;

    // ************************************************************
    // per-lane monitor result
    // ************************************************************

    // err_count saturates and only reset clears it
    typedef struct packed {
        logic        link_up;
        logic [15:0] err_count;
    } lane_stat_t;

endpackage

`default_nettype wire

// File: hdl/xcvr_data_adapter.sv
// fixed at 8-bit data with 8b/10b control, no channel reconfiguration mode
// rate-match status in RX bundle bits 14:13 is not decoded
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module xcvr_data_adapter (
    input  wire xcvr_pkg::tx_word_t tx_words [`XCVR_LANES*`XCVR_SER_WORDS],
    output wire logic [`XCVR_LANES*`XCVR_TX_LANE_W-1:0] tx_native,
    input  wire logic [`XCVR_LANES*`XCVR_RX_LANE_W-1:0] rx_native,
    output xcvr_pkg::rx_word_t rx_words [`XCVR_LANES*`XCVR_SER_WORDS]
);

    localparam int LANES = `XCVR_LANES;
    localparam int SER   = `XCVR_SER_WORDS;
    localparam int SKIP  = `XCVR_SKIP_WORD;
    localparam int TX_B  = `XCVR_TX_BUNDLE;
    localparam int RX_B  = `XCVR_RX_BUNDLE;
    localparam int TX_W  = `XCVR_TX_LANE_W;
    localparam int RX_W  = `XCVR_RX_LANE_W;

    for (genvar l = 0; l < LANES; l++) begin : g_lane

        // ********************************************************
        // TX packing
        // ********************************************************

        // one lane's native word before it joins the bus
        logic [TX_W-1:0] tx_lane;

        // word w sits at w*11*SKIP, so with SKIP of 2 every other
        // bundle slot is left empty and must read as zero
        always_comb begin
            tx_lane = '0;
            for (int w = 0; w < SER; w++) begin
                tx_lane[w*TX_B*SKIP +: TX_B] = tx_words[l*SER+w];
            end
        end

        assign tx_native[l*TX_W +: TX_W] = tx_lane;

        // ********************************************************
        // RX unpacking
        // ********************************************************

        for (genvar w = 0; w < SER; w++) begin : g_word
            // first bit of this word's 16-bit status bundle
            localparam int RB = l*RX_W + w*RX_B*SKIP;

            // bit 9 is the code violation flag and bit 10 the aligner state
            assign rx_words[l*SER+w] = '{
                runningdisp:   rx_native[RB+15],
                patterndetect: rx_native[RB+12],
                disperr:       rx_native[RB+11],
                syncstatus:    rx_native[RB+10],
                errdetect:     rx_native[RB+9],
                k:             rx_native[RB+8],
                data:          rx_native[RB +: 8]
            };
        end
    end

endmodule

`default_nettype wire

// File: hdl/pcs_lpbk_model.sv
// behavioral PCS in parallel loopback, no real 8b/10b coding or serializer
// disparity is modeled as byte parity; the rate-match bits are always 00
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module pcs_lpbk_model (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic [`XCVR_LANES*`XCVR_TX_LANE_W-1:0] tx_native,
    output logic [`XCVR_LANES*`XCVR_RX_LANE_W-1:0] rx_native
);

    localparam int LANES = `XCVR_LANES;
    localparam int SER   = `XCVR_SER_WORDS;
    localparam int SKIP  = `XCVR_SKIP_WORD;
    localparam int TX_B  = `XCVR_TX_BUNDLE;
    localparam int RX_B  = `XCVR_RX_BUNDLE;
    localparam int TX_W  = `XCVR_TX_LANE_W;
    localparam int RX_W  = `XCVR_RX_LANE_W;
    localparam int CCW   = $clog2(`XCVR_SYNC_COMMAS + 1);
    localparam int ECW   = $clog2(`XCVR_SYNC_LOSS + 1);

    // first pipeline stage holds the native TX word
    logic [LANES*TX_W-1:0] tx_q;
    logic [LANES*RX_W-1:0] rx_d;

    // per-lane running disparity, aligner state and its two counters
    logic [LANES-1:0]          rd_q, rd_d;
    logic [LANES-1:0]          sync_q, sync_d;
    logic [LANES-1:0][CCW-1:0] comma_q, comma_d;
    logic [LANES-1:0][ECW-1:0] erun_q, erun_d;

    // the twelve legal 8b/10b control codes
    function automatic logic valid_k(input logic [7:0] d);
        case (d)
            8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
            8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE: valid_k = 1'b1;
            default: valid_k = 1'b0;
        endcase
    endfunction

    // ************************************************************
    // status bundles and aligner update
    // ************************************************************

    always_comb begin : p_status
        xcvr_pkg::tx_word_t tw;
        logic rd;
        logic any_err;
        logic ed;
        logic de;
        int   tb;
        int   rb;

        rx_d    = '0;
        rd_d    = rd_q;
        sync_d  = sync_q;
        comma_d = comma_q;
        erun_d  = erun_q;
        for (int l = 0; l < LANES; l++) begin
            rd      = rd_q[l];
            any_err = 1'b0;
            // words are taken in order so disparity chains through the cycle
            for (int w = 0; w < SER; w++) begin
                tb = l*TX_W + w*TX_B*SKIP;
                rb = l*RX_W + w*RX_B*SKIP;
                tw = tx_q[tb +: TX_B];
                ed = tw.k && !valid_k(tw.data);
                // forcing the disparity the line already has is illegal
                de = tw.forcedisp && (tw.dispval == rd);
                if (tw.forcedisp) begin
                    rd = tw.dispval;
                end else if (^tw.data) begin
                    rd = ~rd;
                end
                any_err = any_err | ed | de;
                rx_d[rb +: 8] = tw.data;
                rx_d[rb+8]    = tw.k;
                rx_d[rb+9]    = ed;
                rx_d[rb+11]   = de;
                rx_d[rb+12]   = tw.k && (tw.data == 8'hBC);
                rx_d[rb+15]   = rd;
            end
            rd_d[l] = rd;

            // only word 0 is watched for commas
            tw = tx_q[l*TX_W +: TX_B];
            if (tw.k && (tw.data == 8'hBC)) begin
                if (comma_q[l] != CCW'(`XCVR_SYNC_COMMAS)) begin
                    comma_d[l] = comma_q[l] + 1'b1;
                end
            end else begin
                comma_d[l] = '0;
            end

            // the error run is only counted while the lane is aligned
            if (!sync_q[l]) begin
                erun_d[l] = '0;
                if (comma_d[l] == CCW'(`XCVR_SYNC_COMMAS)) begin
                    sync_d[l] = 1'b1;
                end
            end else begin
                erun_d[l] = any_err ? erun_q[l] + 1'b1 : '0;
                if (erun_d[l] == ECW'(`XCVR_SYNC_LOSS)) begin
                    sync_d[l] = 1'b0;
                    erun_d[l] = '0;
                end
            end

            // every word of the lane reports the updated aligner state
            for (int w = 0; w < SER; w++) begin
                rb = l*RX_W + w*RX_B*SKIP;
                rx_d[rb+10] = sync_d[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_q      <= '0;
            rx_native <= '0;
            rd_q      <= '0;
            sync_q    <= '0;
            comma_q   <= '0;
            erun_q    <= '0;
        end else begin
            tx_q      <= tx_native;
            rx_native <= rx_d;
            rd_q      <= rd_d;
            sync_q    <= sync_d;
            comma_q   <= comma_d;
            erun_q    <= erun_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rx_link_monitor.sv
// per-lane link state and error count, one cycle behind rx_words
// the error counter saturates and only reset clears it
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module rx_link_monitor (
    input  wire logic clk,
    input  wire logic rst,
    input  wire xcvr_pkg::rx_word_t rx_words [`XCVR_LANES*`XCVR_SER_WORDS],
    output xcvr_pkg::lane_stat_t lane_stat [`XCVR_LANES]
);

    localparam int LANES = `XCVR_LANES;
    localparam int SER   = `XCVR_SER_WORDS;
    // wide enough to count every word of a lane in one cycle
    localparam int NW    = $clog2(SER + 1);

    logic [LANES-1:0][15:0] cnt_d;

    // ************************************************************
    // saturating error count
    // ************************************************************

    always_comb begin : p_count
        logic [NW-1:0] nerr;
        logic [16:0]   sum;

        for (int l = 0; l < LANES; l++) begin
            nerr = '0;
            // a word with both flags set still counts once
            for (int w = 0; w < SER; w++) begin
                nerr = nerr + NW'(rx_words[l*SER+w].errdetect | rx_words[l*SER+w].disperr);
            end
            // the extra top bit catches the wrap past 16'hFFFF
            sum = {1'b0, lane_stat[l].err_count} + 17'(nerr);
            cnt_d[l] = sum[16] ? 16'hFFFF : sum[15:0];
        end
    end

    // ************************************************************
    // registered lane status
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANES; l++) begin
                lane_stat[l] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                // word 0 carries the lane's aligner state like all others
                lane_stat[l].link_up   <= rx_words[l*SER].syncstatus;
                lane_stat[l].err_count <= cnt_d[l];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/xcvr_lpbk_top.sv
// loopback subsystem with no handshake, data is valid on every cycle
// rx_words follow tx_words by 2 cycles and lane_stat follows by 3
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module xcvr_lpbk_top (
    input  wire logic clk,
    input  wire logic rst,
    input  wire xcvr_pkg::tx_word_t tx_words [`XCVR_LANES*`XCVR_SER_WORDS],
    output xcvr_pkg::rx_word_t   rx_words  [`XCVR_LANES*`XCVR_SER_WORDS],
    output xcvr_pkg::lane_stat_t lane_stat [`XCVR_LANES]
);

    // ************************************************************
    // native PCS side of the adapter
    // ************************************************************

    // spaced 11-bit bundles toward the PCS
    wire logic [`XCVR_LANES*`XCVR_TX_LANE_W-1:0] tx_native;
    // spaced 16-bit status bundles back from the PCS
    wire logic [`XCVR_LANES*`XCVR_RX_LANE_W-1:0] rx_native;

    // struct words in and out, native lane words toward the PCS
    xcvr_data_adapter i_adapter (
        .tx_words  (tx_words),
        .tx_native (tx_native),
        .rx_native (rx_native),
        .rx_words  (rx_words)
    );

    // two register stages between tx_native and rx_native
    pcs_lpbk_model i_pcs (
        .clk       (clk),
        .rst       (rst),
        .tx_native (tx_native),
        .rx_native (rx_native)
    );

    // ************************************************************
    // link status
    // ************************************************************

    // watches the same unpacked words that leave the top level
    rx_link_monitor i_monitor (
        .clk       (clk),
        .rst       (rst),
        .rx_words  (rx_words),
        .lane_stat (lane_stat)
    );

endmodule

`default_nettype wire

// File: tests/xcvr_lpbk_sva.sv
// assertions bound into xcvr_lpbk_top, sampled on the rising clock edge
// properties are disabled while rst is high
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module xcvr_lpbk_sva (
    input wire logic clk,
    input wire logic rst,
    input wire xcvr_pkg::tx_word_t   tx_words  [`XCVR_LANES*`XCVR_SER_WORDS],
    input wire xcvr_pkg::rx_word_t   rx_words  [`XCVR_LANES*`XCVR_SER_WORDS],
    input wire xcvr_pkg::lane_stat_t lane_stat [`XCVR_LANES]
);

    localparam int LANES = `XCVR_LANES;
    localparam int SER   = `XCVR_SER_WORDS;
    localparam int N     = LANES*SER;

    // failure counts, one per property, read by the testbench
    int unsigned fail_pass  = 0;
    int unsigned fail_reset = 0;
    int unsigned fail_link  = 0;
    int unsigned fail_count = 0;

    // bit 0 means one clean cycle after reset, bit 1 means two
    logic [1:0]             live;
    logic [N-1:0][8:0]      tx_dk;
    logic [N-1:0][8:0]      rx_dk;
    logic [N-1:0]           sync_all;
    logic [LANES-1:0]       sync0_vec;
    logic [LANES-1:0]       link_vec;
    logic [LANES-1:0][15:0] cnt_vec;

    // true when no lane counter went below its previous value
    function automatic logic no_decrease(input logic [LANES-1:0][15:0] cur,
                                         input logic [LANES-1:0][15:0] prev);
        logic ok;
        ok = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            ok = ok && (cur[l] >= prev[l]);
        end
        return ok;
    endfunction

    // ************************************************************
    // flattened views of the word arrays
    // ************************************************************

    always_comb begin
        for (int i = 0; i < N; i++) begin
            tx_dk[i]    = {tx_words[i].k, tx_words[i].data};
            rx_dk[i]    = {rx_words[i].k, rx_words[i].data};
            sync_all[i] = rx_words[i].syncstatus;
        end
        for (int l = 0; l < LANES; l++) begin
            sync0_vec[l] = rx_words[l*SER].syncstatus;
            link_vec[l]  = lane_stat[l].link_up;
            cnt_vec[l]   = lane_stat[l].err_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '0;
        end else begin
            live <= {live[0], 1'b1};
        end
    end

    // ************************************************************
    // properties
    // ************************************************************

    // data and K come back two cycles after they were sent
    a_passthrough: assert property (@(posedge clk) disable iff (rst)
        live[1] |-> (rx_dk == $past(tx_dk, 2)))
        else begin
            fail_pass++;
            $error("rx data or K differ from the tx words two cycles earlier");
        end

    a_reset_state: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> (sync_all == '0) && (link_vec == '0) && (cnt_vec == '0))
        else begin
            fail_reset++;
            $error("sync, link or error count not cleared after reset");
        end

    // link_up is word 0 syncstatus delayed by one register
    a_link_follow: assert property (@(posedge clk) disable iff (rst)
        live[0] |-> (link_vec == $past(sync0_vec)))
        else begin
            fail_link++;
            $error("link_up does not follow word 0 syncstatus");
        end

    a_count_mono: assert property (@(posedge clk) disable iff (rst)
        live[0] |-> no_decrease(cnt_vec, $past(cnt_vec)))
        else begin
            fail_count++;
            $error("an error counter went down");
        end

endmodule

bind xcvr_lpbk_top xcvr_lpbk_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .tx_words  (tx_words),
    .rx_words  (rx_words),
    .lane_stat (lane_stat)
);

`default_nettype wire

// File: tests/tb_xcvr_lpbk.sv
// self-checking testbench with a cycle model of the PCS and monitor rules
// inputs change on the falling edge and outputs are checked there too
`timescale 1ns/1ps
`default_nettype none
`include "xcvr_cfg.svh"

module tb_xcvr_lpbk;

    localparam int LANES = `XCVR_LANES;
    localparam int SER   = `XCVR_SER_WORDS;
    localparam int N     = LANES*SER;
    // phase lengths in cycles with the reset phase first
    localparam int P_RST = 5;
    localparam int P_SYN = 10;
    localparam int P_RND = 60;
    localparam int P_BAD = 6;
    localparam int P_REC = 12;
    localparam int LIMIT = P_RST + P_SYN + P_RND + P_BAD + P_REC + 50;

    logic                 clk;
    logic                 rst;
    xcvr_pkg::tx_word_t   tx_words  [N];
    xcvr_pkg::rx_word_t   rx_words  [N];
    xcvr_pkg::lane_stat_t lane_stat [LANES];

    // pipe0 holds the model words sent this cycle and pipe1 those of the last cycle
    xcvr_pkg::rx_word_t pipe0 [N];
    xcvr_pkg::rx_word_t pipe1 [N];
    logic [LANES-1:0]   m_rd;
    logic [LANES-1:0]   m_sync;
    int                 m_comma [LANES];
    int                 m_erun  [LANES];
    logic [LANES-1:0]   exp_link;
    int                 exp_cnt [LANES];
    int                 errors;
    int                 cycles;
    logic [7:0]         k_table [12] = '{8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
                                         8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE};

    xcvr_lpbk_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .tx_words  (tx_words),
        .rx_words  (rx_words),
        .lane_stat (lane_stat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_k_code(input logic [7:0] d);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 12; i++) begin
            hit = hit || (k_table[i] == d);
        end
        return hit;
    endfunction

    // ************************************************************
    // stimulus
    // ************************************************************

    // without allow_err the word is a valid K or plain data and never forced
    function automatic xcvr_pkg::tx_word_t rand_word(input logic allow_err);
        xcvr_pkg::tx_word_t tw;
        tw.data      = 8'($urandom);
        tw.k         = ($urandom_range(3) == 0);
        tw.forcedisp = allow_err && ($urandom_range(3) == 0);
        tw.dispval   = 1'($urandom);
        if (tw.k && (!allow_err || $urandom_range(1) == 0)) begin
            tw.data = k_table[$urandom_range(11)];
        end
        return tw;
    endfunction

    function automatic xcvr_pkg::tx_word_t bad_k_word();
        xcvr_pkg::tx_word_t tw;
        tw = '0;
        tw.k = 1'b1;
        do begin
            tw.data = 8'($urandom);
        end while (is_k_code(tw.data));
        return tw;
    endfunction

    // phase 2 errors land on even cycles only, so no lane sees four in a row
    task automatic fill_words(input int phase, input int idx);
        for (int i = 0; i < N; i++) begin
            tx_words[i] = '{dispval: 1'b0, forcedisp: 1'b0, k: 1'b1, data: 8'hBC};
            if (phase == 2) begin
                tx_words[i] = rand_word(idx % 2 == 0);
            end else if (phase == 3 && i < SER) begin
                tx_words[i] = bad_k_word();
            end
        end
    endtask

    // ************************************************************
    // reference model
    // ************************************************************

    task automatic model_cycle();
        xcvr_pkg::tx_word_t tw;
        xcvr_pkg::rx_word_t rw;
        logic lane_err;
        for (int l = 0; l < LANES; l++) begin
            lane_err = 1'b0;
            for (int w = 0; w < SER; w++) begin
                tw = tx_words[l*SER+w];
                rw = '0;
                rw.data          = tw.data;
                rw.k             = tw.k;
                rw.patterndetect = tw.k && (tw.data == 8'hBC);
                rw.errdetect     = tw.k && !is_k_code(tw.data);
                rw.disperr       = tw.forcedisp && (tw.dispval == m_rd[l]);
                if (tw.forcedisp) begin
                    m_rd[l] = tw.dispval;
                end else if (^tw.data) begin
                    m_rd[l] = ~m_rd[l];
                end
                rw.runningdisp   = m_rd[l];
                lane_err         = lane_err || rw.errdetect || rw.disperr;
                pipe0[l*SER+w]   = rw;
            end
            // word 0 drives the aligner
            m_comma[l] = pipe0[l*SER].patterndetect ? m_comma[l] + 1 : 0;
            if (!m_sync[l]) begin
                m_erun[l] = 0;
                m_sync[l] = (m_comma[l] >= `XCVR_SYNC_COMMAS);
            end else begin
                m_erun[l] = lane_err ? m_erun[l] + 1 : 0;
                if (m_erun[l] >= `XCVR_SYNC_LOSS) begin
                    m_sync[l] = 1'b0;
                    m_erun[l] = 0;
                end
            end
            for (int w = 0; w < SER; w++) begin
                pipe0[l*SER+w].syncstatus = m_sync[l];
            end
        end
    endtask

    // the words now on rx_words set lane_stat for the next cycle
    task automatic monitor_update();
        int n;
        for (int l = 0; l < LANES; l++) begin
            n = 0;
            for (int w = 0; w < SER; w++) begin
                n += int'(pipe1[l*SER+w].errdetect || pipe1[l*SER+w].disperr);
            end
            exp_link[l] = pipe1[l*SER].syncstatus;
            exp_cnt[l]  = (exp_cnt[l] + n > 65535) ? 65535 : exp_cnt[l] + n;
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < N; i++) begin
            if (rx_words[i] !== pipe1[i]) begin
                errors++;
                $display("MISMATCH %0t: rx word %0d is %h, expected %h",
                         $time, i, rx_words[i], pipe1[i]);
            end
        end
        for (int l = 0; l < LANES; l++) begin
            if (lane_stat[l] !== {exp_link[l], 16'(exp_cnt[l])}) begin
                errors++;
                $display("MISMATCH %0t: lane %0d status is %h, expected %h",
                         $time, l, lane_stat[l], {exp_link[l], 16'(exp_cnt[l])});
            end
        end
    endtask

    task automatic step(input int phase, input int idx);
        @(negedge clk);
        check_outputs();
        monitor_update();
        pipe1 = pipe0;
        rst = 1'b0;
        fill_words(phase, idx);
        model_cycle();
    endtask

    // ************************************************************
    // run control
    // ************************************************************

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int sva_fails;
        void'($urandom(32'he5a5_c155));
        rst = 1'b1;
        errors = 0;
        cycles = 0;
        m_rd = '0;
        m_sync = '0;
        exp_link = '0;
        for (int i = 0; i < N; i++) begin
            tx_words[i] = '0;
            pipe0[i] = '0;
            pipe1[i] = '0;
        end
        for (int l = 0; l < LANES; l++) begin
            m_comma[l] = 0;
            m_erun[l] = 0;
            exp_cnt[l] = 0;
        end
        repeat (P_RST) @(posedge clk);
        for (int i = 0; i < P_SYN; i++) step(1, i);
        for (int i = 0; i < P_RND; i++) step(2, i);
        for (int i = 0; i < P_BAD; i++) step(3, i);
        for (int i = 0; i < P_REC; i++) step(4, i);
        // the last two cycles of words are still inside the two-stage pipeline
        repeat (2) begin
            @(negedge clk);
            check_outputs();
            monitor_update();
            pipe1 = pipe0;
        end
        sva_fails = i_dut.i_sva.fail_pass + i_dut.i_sva.fail_reset
                  + i_dut.i_sva.fail_link + i_dut.i_sva.fail_count;
        $display("summary: %0d model mismatches, %0d assertion failures", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/xcvr_pkg.sv
hdl/xcvr_data_adapter.sv
hdl/pcs_lpbk_model.sv
hdl/rx_link_monitor.sv
hdl/xcvr_lpbk_top.sv
tests/xcvr_lpbk_sva.sv
tests/tb_xcvr_lpbk.sv

// File: Makefile
# Verilator build and run of the loopback testbench

VERILATOR ?= verilator
TOP       := tb_xcvr_lpbk
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
